// ==== source/aud_pkg.sv ====
package aud_pkg;

    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 20;                // Matches the recorder address range

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [ADDR_W-1:0]   addr_t;

    // Code is reported in STATUS[2:0]
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_WAIT   = 3'd1,
        S_REC    = 3'd2,
        S_PAUSE  = 3'd3,
        S_FINISH = 3'd4
    } rec_state_e;

    typedef struct packed {
        logic start;
        logic pause;                             // Toggles pause and resume
        logic stop;
    } rec_cmd_t;

    typedef struct packed {
        addr_t   addr;
        sample_t data;
    } sample_wr_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        addr_t   adr;
        sample_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        sample_t dat;
    } wb_rsp_t;

    localparam int REG_CTRL   = 0;
    localparam int REG_STATUS = 1;
    localparam int REG_COUNT  = 2;

endpackage

// ==== source/aud_recorder.sv ====
`timescale 1ns/1ps

module aud_recorder #(
    parameter int P_RAM_AW = 8
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  aud_pkg::rec_cmd_t    i_cmd,
    input  logic                 i_lrc,
    input  logic                 i_data,
    output logic                 o_wr_valid,
    output aud_pkg::sample_wr_t  o_wr,
    output aud_pkg::rec_state_e  o_state,
    output logic                 o_finish,
    output aud_pkg::addr_t       o_count
);

    localparam int CNT_W = $clog2(aud_pkg::SAMPLE_W + 1);
    localparam logic [CNT_W-1:0] WORD_DONE = CNT_W'(aud_pkg::SAMPLE_W);
    localparam aud_pkg::addr_t FULL_ADDR = aud_pkg::addr_t'(1) << P_RAM_AW;

    aud_pkg::rec_state_e state_r, state_w;
    aud_pkg::addr_t      addr_r, addr_w;
    aud_pkg::sample_t    shift_r, shift_w;
    aud_pkg::sample_wr_t wr_r, wr_w;
    logic [CNT_W-1:0]    cnt_r, cnt_w;
    logic                finish_r, finish_w;
    logic                pend_r, pend_w;
    logic                wr_valid_r, wr_valid_w;
    logic                lrc_r;
    logic                frame_start;

    assign frame_start = lrc_r && !i_lrc;        // Left half begins

    assign o_wr_valid = wr_valid_r;
    assign o_wr       = wr_r;
    assign o_state    = state_r;
    assign o_finish   = finish_r;
    assign o_count    = addr_r;

    always_comb begin
        state_w    = state_r;
        addr_w     = addr_r;
        shift_w    = shift_r;
        wr_w       = wr_r;
        cnt_w      = cnt_r;
        finish_w   = finish_r;
        pend_w     = pend_r;
        wr_valid_w = 1'b0;
        case (state_r)
            aud_pkg::S_IDLE: begin
                if (i_cmd.start) begin
                    state_w  = aud_pkg::S_WAIT;
                    addr_w   = '0;
                    cnt_w    = '0;
                    finish_w = 1'b0;
                    pend_w   = 1'b0;
                end
            end
            aud_pkg::S_WAIT: begin
                if (i_cmd.stop) begin
                    finish_w = 1'b1;
                    state_w  = aud_pkg::S_FINISH;
                end else if (i_cmd.pause) begin
                    state_w = aud_pkg::S_PAUSE;          // No word in progress
                end else if (frame_start) begin
                    shift_w = {shift_r[aud_pkg::SAMPLE_W-2:0], i_data};
                    cnt_w   = CNT_W'(1);
                    state_w = aud_pkg::S_REC;
                end
            end
            aud_pkg::S_REC: begin
                if (i_cmd.pause) begin
                    pend_w = 1'b1;
                end
                if (cnt_r == WORD_DONE) begin
                    wr_valid_w = 1'b1;
                    wr_w.addr  = addr_r;
                    wr_w.data  = shift_r;
                    addr_w     = addr_r + 1'b1;
                    cnt_w      = '0;
                    if (addr_w == FULL_ADDR || i_cmd.stop) begin
                        finish_w = 1'b1;
                        state_w  = aud_pkg::S_FINISH;
                    end else if (pend_w) begin
                        pend_w  = 1'b0;
                        state_w = aud_pkg::S_PAUSE;
                    end
                end else if (cnt_r != '0) begin
                    if (i_cmd.stop) begin
                        cnt_w    = '0;                   // Drop partial word
                        finish_w = 1'b1;
                        state_w  = aud_pkg::S_FINISH;
                    end else begin
                        shift_w = {shift_r[aud_pkg::SAMPLE_W-2:0], i_data};
                        cnt_w   = cnt_r + 1'b1;
                    end
                end else begin
                    // Between words
                    if (i_cmd.stop) begin
                        finish_w = 1'b1;
                        state_w  = aud_pkg::S_FINISH;
                    end else if (pend_w) begin
                        pend_w  = 1'b0;
                        state_w = aud_pkg::S_PAUSE;
                    end else if (frame_start) begin
                        shift_w = {shift_r[aud_pkg::SAMPLE_W-2:0], i_data};
                        cnt_w   = CNT_W'(1);
                    end
                end
            end
            aud_pkg::S_PAUSE: begin
                if (i_cmd.stop) begin
                    finish_w = 1'b1;
                    state_w  = aud_pkg::S_FINISH;
                end else if (i_cmd.pause) begin
                    state_w = aud_pkg::S_WAIT;           // Resume on next frame
                end
            end
            aud_pkg::S_FINISH: begin
                state_w = aud_pkg::S_IDLE;
            end
            default: begin
                state_w = aud_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r    <= aud_pkg::S_IDLE;
            addr_r     <= '0;
            cnt_r      <= '0;
            finish_r   <= 1'b0;
            pend_r     <= 1'b0;
            wr_valid_r <= 1'b0;
            lrc_r      <= 1'b0;
        end else begin
            state_r    <= state_w;
            addr_r     <= addr_w;
            cnt_r      <= cnt_w;
            finish_r   <= finish_w;
            pend_r     <= pend_w;
            wr_valid_r <= wr_valid_w;
            lrc_r      <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
        wr_r    <= wr_w;
    end

endmodule

// ==== source/aud_sample_writer.sv ====
`timescale 1ns/1ps

module aud_sample_writer (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_clr,
    input  logic                 i_wr_valid,
    input  aud_pkg::sample_wr_t  i_wr,
    output aud_pkg::wb_req_t     o_wb,
    input  aud_pkg::wb_rsp_t     i_wb,
    output logic                 o_overflow
);

    localparam int DEPTH = 4;
    localparam int PTR_W = $clog2(DEPTH);

    aud_pkg::sample_wr_t fifo_mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_r;
    logic [PTR_W-1:0]    rd_ptr_r;
    logic [PTR_W:0]      level_r;
    logic                stb_r;
    logic                overflow_r;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;

    assign full  = (level_r == (PTR_W + 1)'(DEPTH));
    assign empty = (level_r == '0);
    assign push  = i_wr_valid && !full;
    assign pop   = stb_r && i_wb.ack;            // Write accepted by memory

    always_ff @(posedge i_clk) begin
        if (push) begin
            fifo_mem[wr_ptr_r] <= i_wr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            level_r    <= '0;
            stb_r      <= 1'b0;
            overflow_r <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            level_r <= level_r + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
            if (pop) begin
                stb_r <= 1'b0;                   // One idle cycle between writes
            end else if (!empty) begin
                stb_r <= 1'b1;
            end
            if (i_clr) begin
                overflow_r <= 1'b0;
            end else if (i_wr_valid && full) begin
                overflow_r <= 1'b1;              // Sticky until next start
            end
        end
    end

    always_comb begin
        o_wb.cyc = stb_r;
        o_wb.stb = stb_r;
        o_wb.we  = stb_r;
        o_wb.adr = fifo_mem[rd_ptr_r].addr;
        o_wb.dat = fifo_mem[rd_ptr_r].data;
    end

    assign o_overflow = overflow_r;

endmodule

// ==== source/aud_sample_ram.sv ====
`timescale 1ns/1ps

module aud_sample_ram #(
    parameter int P_RAM_AW = 8
) (
    input  logic              i_clk,
    input  aud_pkg::wb_req_t  i_wb,
    output aud_pkg::wb_rsp_t  o_wb,
    input  aud_pkg::addr_t    i_rd_addr,
    output aud_pkg::sample_t  o_rd_data
);

    localparam int DEPTH = 1 << P_RAM_AW;

    aud_pkg::sample_t mem [DEPTH];
    aud_pkg::sample_t rd_data_r;
    logic             ack_r;
    logic             wb_req;

    assign wb_req = i_wb.cyc && i_wb.stb && !ack_r;  // First cycle of a write

    always_ff @(posedge i_clk) begin
        ack_r <= wb_req;
        if (wb_req && i_wb.we) begin
            mem[i_wb.adr[P_RAM_AW-1:0]] <= i_wb.dat;
        end
    end

    // Host read port
    always_ff @(posedge i_clk) begin
        rd_data_r <= mem[i_rd_addr[P_RAM_AW-1:0]];
    end

    assign o_wb.ack  = ack_r;
    assign o_wb.dat  = '0;                       // Write-only port
    assign o_rd_data = rd_data_r;

endmodule

// ==== source/aud_host_regs.sv ====
`timescale 1ns/1ps

module aud_host_regs #(
    parameter int P_RAM_AW = 8
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  aud_pkg::wb_req_t     i_wb,
    output aud_pkg::wb_rsp_t     o_wb,
    output aud_pkg::rec_cmd_t    o_cmd,
    input  aud_pkg::rec_state_e  i_state,
    input  logic                 i_finish,
    input  logic                 i_overflow,
    input  aud_pkg::addr_t       i_count,
    output aud_pkg::addr_t       o_rd_addr,
    input  aud_pkg::sample_t     i_rd_data
);

    localparam aud_pkg::addr_t MEM_MASK = (aud_pkg::addr_t'(1) << P_RAM_AW) - 1'b1;

    aud_pkg::rec_cmd_t cmd_r;
    aud_pkg::sample_t  reg_dat;
    aud_pkg::sample_t  reg_dat_r;
    logic              ack_r;
    logic              mem_sel_r;
    logic              mem_sel;
    logic              req;
    logic              ctrl_wr;

    assign req     = i_wb.cyc && i_wb.stb && !ack_r;
    assign mem_sel = i_wb.adr[P_RAM_AW];
    assign ctrl_wr = req && i_wb.we && (i_wb.adr == aud_pkg::addr_t'(aud_pkg::REG_CTRL));

    always_comb begin
        reg_dat = '0;
        case (i_wb.adr)
            aud_pkg::addr_t'(aud_pkg::REG_STATUS): begin
                reg_dat[2:0] = i_state;
                reg_dat[3]   = i_finish;
                reg_dat[4]   = i_overflow;
            end
            aud_pkg::addr_t'(aud_pkg::REG_COUNT): begin
                reg_dat = aud_pkg::sample_t'(i_count);
            end
            default: begin
                reg_dat = '0;                    // CTRL and unmapped read as zero
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            ack_r <= 1'b0;
            cmd_r <= '0;
        end else begin
            ack_r <= req;
            if (ctrl_wr) begin
                cmd_r.start <= i_wb.dat[0];
                cmd_r.pause <= i_wb.dat[1];
                cmd_r.stop  <= i_wb.dat[2];
            end else begin
                cmd_r <= '0;                     // Single-cycle pulses
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            reg_dat_r <= reg_dat;
            mem_sel_r <= mem_sel;
        end
    end

    // Memory data arrives in the ack cycle
    assign o_rd_addr = i_wb.adr & MEM_MASK;
    assign o_wb.ack  = ack_r;
    assign o_wb.dat  = mem_sel_r ? i_rd_data : reg_dat_r;
    assign o_cmd     = cmd_r;

endmodule

// ==== source/aud_top.sv ====
`timescale 1ns/1ps

module aud_top #(
    parameter int P_RAM_AW = 8
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_lrc,
    input  logic              i_data,
    input  aud_pkg::wb_req_t  i_wb,
    output aud_pkg::wb_rsp_t  o_wb
);

    aud_pkg::rec_cmd_t   rec_cmd;
    aud_pkg::rec_state_e rec_state;
    aud_pkg::sample_wr_t wr;
    aud_pkg::addr_t      rec_count;
    aud_pkg::addr_t      rd_addr;
    aud_pkg::sample_t    rd_data;
    aud_pkg::wb_req_t    mem_req;
    aud_pkg::wb_rsp_t    mem_rsp;
    logic                wr_valid;
    logic                rec_finish;
    logic                overflow;

    aud_recorder #(
        .P_RAM_AW   (P_RAM_AW)
    ) u_aud_recorder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (rec_cmd),
        .i_lrc      (i_lrc),
        .i_data     (i_data),
        .o_wr_valid (wr_valid),
        .o_wr       (wr),
        .o_state    (rec_state),
        .o_finish   (rec_finish),
        .o_count    (rec_count)
    );

    aud_sample_writer u_aud_sample_writer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clr      (rec_cmd.start),             // Start clears overflow
        .i_wr_valid (wr_valid),
        .i_wr       (wr),
        .o_wb       (mem_req),
        .i_wb       (mem_rsp),
        .o_overflow (overflow)
    );

    aud_sample_ram #(
        .P_RAM_AW   (P_RAM_AW)
    ) u_aud_sample_ram (
        .i_clk      (i_clk),
        .i_wb       (mem_req),
        .o_wb       (mem_rsp),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (rd_data)
    );

    aud_host_regs #(
        .P_RAM_AW   (P_RAM_AW)
    ) u_aud_host_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (i_wb),
        .o_wb       (o_wb),
        .o_cmd      (rec_cmd),
        .i_state    (rec_state),
        .i_finish   (rec_finish),
        .i_overflow (overflow),
        .i_count    (rec_count),
        .o_rd_addr  (rd_addr),
        .i_rd_data  (rd_data)
    );

endmodule

// ==== tb/aud_tb.sv ====
`timescale 1ns/1ps

module aud_tb;

    localparam int RAM_AW      = 4;
    localparam int MEM_WORDS   = 1 << RAM_AW;
    localparam int ACK_TIMEOUT = 16;

    logic                clk;
    logic                rst_n;
    logic                lrc;
    logic                sdata;
    aud_pkg::wb_req_t    host_req;
    aud_pkg::wb_rsp_t    host_rsp;
    integer              seed = 32'h5d4e2999;
    aud_pkg::rec_state_e m_state;                    // Reference model of the recorder
    aud_pkg::addr_t      m_count;
    aud_pkg::sample_t    m_mem [MEM_WORDS];

    aud_top #(
        .P_RAM_AW (RAM_AW)
    ) u_aud_top (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_lrc    (lrc),
        .i_data   (sdata),
        .i_wb     (host_req),
        .o_wb     (host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input aud_pkg::sample_t got, exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input aud_pkg::addr_t got, exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_state(input string name, input aud_pkg::rec_state_e got, exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic bus_access(input logic we, input aud_pkg::addr_t adr,
                              input aud_pkg::sample_t wdat, output aud_pkg::sample_t rdat);
        int t;
        host_req = {1'b1, 1'b1, we, adr, wdat};
        t = 0;
        do begin
            @(posedge clk);
            #1;
            t++;
        end while (!host_rsp.ack && t < ACK_TIMEOUT);
        if (!host_rsp.ack) begin
            abort_run($sformatf("timeout waiting for host ack at address %h", adr));
        end
        rdat     = host_rsp.dat;
        host_req = '0;
    endtask

    task automatic wb_write(input aud_pkg::addr_t adr, input aud_pkg::sample_t wdat);
        aud_pkg::sample_t unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input aud_pkg::addr_t adr, output aud_pkg::sample_t rdat);
        bus_access(1'b0, adr, '0, rdat);
    endtask

    task automatic model_cmd(input logic [2:0] cmd);
        if (cmd[0] && m_state == aud_pkg::S_IDLE) begin
            m_state = aud_pkg::S_WAIT;
            m_count = '0;
        end else if (cmd[2] && m_state != aud_pkg::S_IDLE) begin
            m_state = aud_pkg::S_IDLE;
        end else if (cmd[1] && m_state == aud_pkg::S_PAUSE) begin
            m_state = aud_pkg::S_WAIT;               // Resume at next frame
        end else if (cmd[1] && m_state != aud_pkg::S_IDLE) begin
            m_state = aud_pkg::S_PAUSE;
        end
    endtask

    task automatic model_frame(input aud_pkg::sample_t left, input logic [2:0] cmd);
        if (m_state == aud_pkg::S_WAIT || m_state == aud_pkg::S_REC) begin
            if (cmd[2]) begin
                m_state = aud_pkg::S_IDLE;           // Partial word dropped
            end else begin
                m_mem[m_count[RAM_AW-1:0]] = left;
                m_count = m_count + 1'b1;
                m_state = aud_pkg::S_REC;
                if (m_count == MEM_WORDS) begin
                    m_state = aud_pkg::S_IDLE;
                end else if (cmd[1]) begin
                    m_state = aud_pkg::S_PAUSE;      // Word in flight is kept
                end
            end
        end
    endtask

    // Left half MSB first on lrc low and a host command may land mid-word
    task automatic send_frame(input aud_pkg::sample_t left, input logic [2:0] cmd, input int at);
        logic [31:0] bits;
        bits = {left, 16'($random(seed))};
        fork
            for (int i = 0; i < 32; i++) begin
                lrc   = (i >= 16);
                sdata = bits[31-i];
                @(posedge clk);
                #1;
            end
            if (cmd != 3'd0) begin
                repeat (at) begin
                    @(posedge clk);
                    #1;
                end
                wb_write(aud_pkg::addr_t'(aud_pkg::REG_CTRL), aud_pkg::sample_t'(cmd));
            end
        join
        model_frame(left, cmd);
    endtask

    task automatic expect_status(input aud_pkg::addr_t exp_count, input logic exp_finish,
                                 input aud_pkg::rec_state_e exp_state);
        aud_pkg::sample_t rdat;
        check_count("model count", m_count, exp_count);
        wb_read(aud_pkg::addr_t'(aud_pkg::REG_COUNT), rdat);
        check_count("COUNT", aud_pkg::addr_t'(rdat), exp_count);
        wb_read(aud_pkg::addr_t'(aud_pkg::REG_STATUS), rdat);
        check_state("STATUS.state", aud_pkg::rec_state_e'(rdat[2:0]), exp_state);
        check_sample("STATUS.flags", rdat & 16'h0018, {12'd0, exp_finish, 3'd0}); // Overflow 0
        for (int k = 0; k < int'(exp_count); k++) begin
            wb_read(aud_pkg::addr_t'(MEM_WORDS + k), rdat);
            check_sample($sformatf("mem[%0d]", k), rdat, m_mem[k]);
        end
    endtask

    initial begin
        int               fd;
        int               r;
        byte              op;
        logic [31:0]      a, b, c;
        logic [8*160-1:0] skip;
        aud_pkg::sample_t rdat;
        rst_n    = 1'b1;
        lrc      = 1'b1;
        sdata    = 1'b0;
        host_req = '0;
        m_state  = aud_pkg::S_IDLE;
        m_count  = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b0;
        fd = $fopen("tb/aud_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open case file tb/aud_cases.txt");
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": r = $fgets(skip, fd);
                "F": begin
                    r = $fscanf(fd, "%h %h %h", a, b, c);
                    send_frame(a[15:0], b[2:0], int'(c));
                end
                "B": begin
                    r = $fscanf(fd, "%h %h", a, b);
                    for (int k = 0; k < int'(a); k++) begin
                        send_frame(b[15:0] + 16'(k) * 16'h0101, 3'd0, 0);
                    end
                end
                "C": begin
                    r = $fscanf(fd, "%h", a);
                    wb_write(aud_pkg::addr_t'(aud_pkg::REG_CTRL), a[15:0]);
                    @(posedge clk);                  // Recorder takes the pulse here
                    #1;
                    model_cmd(a[2:0]);
                end
                "I": begin
                    r = $fscanf(fd, "%h", a);
                    repeat (a) begin
                        @(posedge clk);
                        #1;
                    end
                end
                "E": begin
                    r = $fscanf(fd, "%h %h %h", a, b, c);
                    expect_status(a[19:0], b[0], aud_pkg::rec_state_e'(c[2:0]));
                end
                "M": begin
                    r = $fscanf(fd, "%h %h", a, b);
                    wb_read(aud_pkg::addr_t'(MEM_WORDS) | a[19:0], rdat);
                    check_sample($sformatf("mem[%0d]", a), rdat, b[15:0]);
                end
                default: abort_run($sformatf("unknown operation %c in case file", op));
            endcase
        end
        $fclose(fd);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== tb/aud_cases.txt ====
# F <left> <cmd> <bit>: one frame, ctrl cmd (2 pause, 4 stop, 0 none) written at bit
# C <cmd>, I <cycles>, B <frames> <base>, E <count> <finish> <state>, M <addr> <word>
I 4
C 1
F a5c3 0 0
F 1234 0 0
F fedc 0 0
I 8
E 3 0 2
F 0f0f 2 6
F 5555 0 0
F 6666 0 0
I 8
E 4 0 3
C 2
F 7777 0 0
F 8001 4 6
I 8
E 5 1 0
M 4 7777
C 1
B 14 1000
I 8
E 10 1 0
M f 1f0f
C 1
F beef 0 0
I 8
E 1 0 2
M 0 beef

// ==== tb.f ====
source/aud_pkg.sv
source/aud_recorder.sv
source/aud_sample_writer.sv
source/aud_sample_ram.sv
source/aud_host_regs.sv
source/aud_top.sv
tb/aud_tb.sv

// ==== Bender.yml ====
package:
  name: aud_capture

sources:
  - source/aud_pkg.sv
  - source/aud_recorder.sv
  - source/aud_sample_writer.sv
  - source/aud_sample_ram.sv
  - source/aud_host_regs.sv
  - source/aud_top.sv
  - target: test
    files:
      - tb/aud_tb.sv
